//--- flist.f
+incdir+hw
hw/mem_pkg.sv
hw/mem_line_if.sv
hw/main_memory.sv
hw/icache.sv
hw/dcache.sv
hw/mem_subsystem_top.sv
tests/mem_subsystem_assertions.sv
tests/mem_subsystem_tb.sv

//--- hw/dcache.sv
`timescale 1ns/100ps
`include "mem_config.svh"

module dcache import mem_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  data_req,
    input  logic  data_we,
    input  word_t data_addr,
    input  word_t data_wdata,
    output logic  data_ack,
    output word_t data_rdata,
    mem_line_if.line_master mem
);

    cache_state_e state;
    mem_addr_u req_addr;
    logic req_we;
    word_t req_wdata;

    logic [`CACHE_LINES-1:0] valid;
    logic [`CACHE_TAG_BITS-1:0] tags [`CACHE_LINES];
    line_t lines [`CACHE_LINES];

    logic [`CACHE_INDEX_BITS-1:0] idx;
    logic [1:0] off;
    logic hit;
    line_t merged; // cached line with the store word in place

    assign idx = req_addr.f.index;
    assign off = req_addr.f.word_off;
    assign hit = valid[idx] && (tags[idx] == req_addr.f.tag);

    always_comb begin
        merged = lines[idx];
        merged[off] = req_wdata;
    end

    // any miss refills first, stores go on to write the line through
    assign mem.read_en = (state == c_refill) || (state == c_lookup && !hit);
    assign mem.write_en = (state == c_write_line) || (state == c_lookup && hit && req_we);
    assign mem.addr = req_addr;
    assign mem.write_data = merged;
    assign data_ack = (state == c_ack_wait);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= c_idle;
            valid <= '0;
        end else begin
            case (state)
                c_idle: begin
                    if (data_req) begin
                        state <= c_lookup;
                    end
                end
                c_lookup: begin
                    if (!hit) begin
                        state <= c_refill;
                    end else if (req_we) begin
                        state <= c_write_line;
                    end else begin
                        state <= c_ack_wait;
                    end
                end
                c_refill: begin
                    if (mem.ready) begin
                        valid[idx] <= 1'b1;
                        state <= req_we ? c_write_line : c_ack_wait; // write-allocate
                    end
                end
                c_write_line: begin
                    if (mem.ready) begin
                        state <= c_ack_wait;
                    end
                end
                c_ack_wait: begin
                    if (!data_req) begin
                        state <= c_idle;
                    end
                end
                default: state <= c_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == c_idle && data_req) begin
            req_addr.raw <= data_addr;
            req_we <= data_we;
            req_wdata <= data_wdata;
        end
        if (state == c_lookup && hit && !req_we) begin
            data_rdata <= lines[idx][off];
        end
        if (state == c_refill && mem.ready) begin
            lines[idx] <= mem.read_data;
            tags[idx] <= req_addr.f.tag;
            if (!req_we) begin
                data_rdata <= mem.read_data[off];
            end
        end
        if (state == c_write_line && mem.ready) begin
            lines[idx] <= merged; // cache matches the store once written
        end
    end

endmodule

//--- hw/icache.sv
`timescale 1ns/100ps
`include "mem_config.svh"

module icache import mem_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  fetch_req,
    input  word_t fetch_addr,
    output logic  fetch_ack,
    output word_t fetch_data,
    mem_line_if.line_reader mem
);

    cache_state_e state;
    mem_addr_u req_addr; // latched fetch address

    logic [`CACHE_LINES-1:0] valid;
    logic [`CACHE_TAG_BITS-1:0] tags [`CACHE_LINES];
    line_t lines [`CACHE_LINES];

    logic [`CACHE_INDEX_BITS-1:0] idx;
    logic [1:0] off;
    logic hit;

    assign idx = req_addr.f.index;
    assign off = req_addr.f.word_off;
    assign hit = valid[idx] && (tags[idx] == req_addr.f.tag);

    // enable already up in lookup so the refill starts without a gap
    assign mem.read_en = (state == c_refill) || (state == c_lookup && !hit);
    assign mem.addr = req_addr;
    assign fetch_ack = (state == c_ack_wait);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= c_idle;
            valid <= '0;
        end else begin
            case (state)
                c_idle: begin
                    if (fetch_req) begin
                        state <= c_lookup;
                    end
                end
                c_lookup: state <= hit ? c_ack_wait : c_refill;
                c_refill: begin
                    if (mem.ready) begin
                        valid[idx] <= 1'b1;
                        state <= c_ack_wait;
                    end
                end
                c_ack_wait: begin
                    if (!fetch_req) begin // four-phase return to zero
                        state <= c_idle;
                    end
                end
                default: state <= c_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == c_idle && fetch_req) begin
            req_addr.raw <= fetch_addr;
        end
        if (state == c_lookup && hit) begin
            fetch_data <= lines[idx][off];
        end
        if (state == c_refill && mem.ready) begin
            lines[idx] <= mem.read_data;
            tags[idx] <= req_addr.f.tag;
            fetch_data <= mem.read_data[off]; // word straight from the refill
        end
    end

endmodule

//--- hw/main_memory.sv
`timescale 1ns/100ps
`include "mem_config.svh"

module main_memory import mem_pkg::*; (
    input logic clk,
    input logic reset,
    mem_line_if.store_rd imem,
    mem_line_if.store_rw dmem
);

    localparam int widx_bits = $clog2(`MEM_WORDS);
    localparam int cnt_bits = $clog2(`MEM_LATENCY + 1);
    localparam logic [cnt_bits-1:0] last_count = cnt_bits'(`MEM_LATENCY - 1);

    word_t mem_array [`MEM_WORDS] = '{default: '0}; // zero image, no boot code

    store_state_e i_state;
    store_state_e d_state;
    logic [cnt_bits-1:0] i_count;
    logic [cnt_bits-1:0] d_count;
    logic [widx_bits-3:0] i_line; // line number, low four address bits dropped
    logic [widx_bits-3:0] d_line;

    assign i_line = imem.addr.raw[widx_bits+1:4];
    assign d_line = dmem.addr.raw[widx_bits+1:4];

    // instruction port, reads only
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            i_state <= s_idle;
            i_count <= '0;
            imem.ready <= 1'b0;
        end else begin
            case (i_state)
                s_idle: begin
                    imem.ready <= 1'b0;
                    i_count <= '0;
                    if (imem.read_en && !imem.ready) begin // held enable not retaken
                        i_state <= s_read;
                    end
                end
                s_read: begin
                    i_count <= i_count + cnt_bits'(1);
                    if (i_count == last_count) begin
                        imem.ready <= 1'b1;
                        i_state <= s_idle;
                    end
                end
                default: i_state <= s_idle;
            endcase
        end
    end

    // data port, reads and line writes
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            d_state <= s_idle;
            d_count <= '0;
            dmem.ready <= 1'b0;
        end else begin
            case (d_state)
                s_idle: begin
                    dmem.ready <= 1'b0;
                    d_count <= '0;
                    if (!dmem.ready) begin
                        if (dmem.read_en) begin
                            d_state <= s_read;
                        end else if (dmem.write_en) begin
                            d_state <= s_write;
                        end
                    end
                end
                s_read, s_write: begin
                    d_count <= d_count + cnt_bits'(1);
                    if (d_count == last_count) begin
                        dmem.ready <= 1'b1;
                        d_state <= s_idle;
                    end
                end
                default: d_state <= s_idle;
            endcase
        end
    end

    // array access happens on the last counted cycle
    always_ff @(posedge clk) begin
        if (i_state == s_read && i_count == last_count) begin
            for (int w = 0; w < 4; w++) begin
                imem.read_data[w] <= mem_array[{i_line, 2'(w)}];
            end
        end
        if (d_state == s_read && d_count == last_count) begin
            for (int w = 0; w < 4; w++) begin
                dmem.read_data[w] <= mem_array[{d_line, 2'(w)}];
            end
        end
        if (d_state == s_write && d_count == last_count) begin
            for (int w = 0; w < 4; w++) begin
                mem_array[{d_line, 2'(w)}] <= dmem.write_data[w];
            end
        end
    end

endmodule

//--- hw/mem_config.svh
`ifndef MEM_CONFIG_SVH
`define MEM_CONFIG_SVH

// backing store size in 32-bit words (64KB)
`define MEM_WORDS 16384

// counted cycles per store access, after the entry cycle
`define MEM_LATENCY 10

// both caches are direct mapped with the same geometry
`define CACHE_INDEX_BITS 4
`define CACHE_LINES (1 << `CACHE_INDEX_BITS)

// 32 address bits minus index, word offset and byte offset
`define CACHE_TAG_BITS (28 - `CACHE_INDEX_BITS)

`endif

//--- hw/mem_line_if.sv
`timescale 1ns/100ps

interface mem_line_if import mem_pkg::*; ();

    logic      read_en;
    logic      write_en;
    mem_addr_u addr;
    line_t     write_data;
    line_t     read_data;
    logic      ready;      // one-cycle pulse from the store

    // instruction cache side, no write path
    modport line_reader (output read_en, addr, input read_data, ready);

    // data cache side
    modport line_master (
        output read_en, write_en, addr, write_data,
        input  read_data, ready
    );

    modport store_rd (input read_en, addr, output read_data, ready);

    modport store_rw (
        input  read_en, write_en, addr, write_data,
        output read_data, ready
    );

endinterface

//--- hw/mem_pkg.sv
`include "mem_config.svh"

package mem_pkg;

    typedef logic [31:0] word_t;

    // word at the lowest address sits in element 0
    typedef word_t [3:0] line_t;

    typedef struct packed {
        logic [`CACHE_TAG_BITS-1:0]   tag;
        logic [`CACHE_INDEX_BITS-1:0] index;
        logic [1:0]                   word_off; // word within line
        logic [1:0]                   byte_off; // unused, word accesses only
    } addr_fields_t;

    // raw view for the store, field view for the caches
    typedef union packed {
        word_t        raw;
        addr_fields_t f;
    } mem_addr_u;

    typedef enum logic [1:0] {
        s_idle,
        s_read,
        s_write
    } store_state_e;

    typedef enum logic [2:0] {
        c_idle,
        c_lookup,
        c_refill,
        c_write_line,
        c_ack_wait
    } cache_state_e;

endpackage

//--- hw/mem_subsystem_top.sv
`timescale 1ns/100ps

module mem_subsystem_top import mem_pkg::*; (
    input  logic  clk,
    input  logic  reset,

    // instruction fetch port
    input  logic  fetch_req,
    input  word_t fetch_addr,
    output logic  fetch_ack,
    output word_t fetch_data,

    // load/store port
    input  logic  data_req,
    input  logic  data_we,
    input  word_t data_addr,
    input  word_t data_wdata,
    output logic  data_ack,
    output word_t data_rdata
);

    mem_line_if i_line ();
    mem_line_if d_line ();

    icache u_icache (
        .clk        (clk),
        .reset      (reset),
        .fetch_req  (fetch_req),
        .fetch_addr (fetch_addr),
        .fetch_ack  (fetch_ack),
        .fetch_data (fetch_data),
        .mem        (i_line.line_reader)
    );

    dcache u_dcache (
        .clk        (clk),
        .reset      (reset),
        .data_req   (data_req),
        .data_we    (data_we),
        .data_addr  (data_addr),
        .data_wdata (data_wdata),
        .data_ack   (data_ack),
        .data_rdata (data_rdata),
        .mem        (d_line.line_master)
    );

    // both ports run independently
    main_memory u_main_memory (
        .clk   (clk),
        .reset (reset),
        .imem  (i_line.store_rd),
        .dmem  (d_line.store_rw)
    );

endmodule

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f flist.f \
    --top-module mem_subsystem_tb -o mem_subsystem_sim &&
./obj_dir/mem_subsystem_sim | tee /dev/stderr | grep "All tests passed" > /dev/null &&
echo "simulation PASS" && exit 0 ||
{ echo "simulation FAIL"; exit 1; }

//--- tests/mem_golden.txt
# columns: op (F fetch, L load, S store), byte address in hex, value in hex
# the value is the store data for S and the expected read word for F and L
L 00000040 00000000
S 00000044 a5a5a5a5
L 00000044 a5a5a5a5
L 00000040 00000000
L 0000004c 00000000
S 00000088 12345678
L 00000088 12345678
L 0000008c 00000000
S 00001000 00000013
S 00001004 00100093
S 00001008 00200113
F 00001004 00100093
F 00001000 00000013
F 00001008 00200113
S 00000100 11111111
S 00000200 22222222
L 00000100 11111111
L 00000200 22222222
S 00000100 33333333
L 00000200 22222222
L 00000100 33333333
F 00001000 00000013
S 00000300 44444444
F 00002000 00000000
L 00000300 44444444
F 00000044 a5a5a5a5

//--- tests/mem_subsystem_assertions.sv
`timescale 1ns/100ps

module mem_subsystem_assertions (
    input logic clk,
    input logic reset,
    input logic fetch_req,
    input logic fetch_ack,
    input logic data_req,
    input logic data_ack,
    input logic i_ready,
    input logic d_ready,
    input logic d_read_en,
    input logic d_write_en
);

    fetch_ack_rise: assert property (@(posedge clk) disable iff (reset)
        $rose(fetch_ack) |-> fetch_req) else $error("fetch_ack rose without fetch_req");
    data_ack_rise: assert property (@(posedge clk) disable iff (reset)
        $rose(data_ack) |-> data_req) else $error("data_ack rose without data_req");

    // four-phase return to zero
    fetch_ack_fall: assert property (@(posedge clk) disable iff (reset)
        $fell(fetch_ack) |-> !fetch_req) else $error("fetch_ack fell while fetch_req high");
    data_ack_fall: assert property (@(posedge clk) disable iff (reset)
        $fell(data_ack) |-> !data_req) else $error("data_ack fell while data_req high");

    i_ready_pulse: assert property (@(posedge clk) disable iff (reset)
        i_ready |=> !i_ready) else $error("instruction port ready held over one cycle");
    d_ready_pulse: assert property (@(posedge clk) disable iff (reset)
        d_ready |=> !d_ready) else $error("data port ready held over one cycle");

    d_enables: assert property (@(posedge clk) disable iff (reset)
        !(d_read_en && d_write_en)) else $error("data port read and write enables both high");

endmodule

bind mem_subsystem_top mem_subsystem_assertions i_assertions (
    .clk, .reset, .fetch_req, .fetch_ack, .data_req, .data_ack,
    .i_ready    (i_line.ready),
    .d_ready    (d_line.ready),
    .d_read_en  (d_line.read_en),
    .d_write_en (d_line.write_en)
);

//--- tests/mem_subsystem_tb.sv
`timescale 1ns/100ps

module mem_subsystem_tb import mem_pkg::*; ();

    localparam int clk_period = 8;
    localparam int reset_cycles = 8;
    localparam int max_entries = 256;
    localparam int cycles_per_entry = 24 + 3 + 4; // store miss, idle gap, handshake

    logic  clk;
    logic  reset;
    logic  fetch_req;
    word_t fetch_addr;
    logic  fetch_ack;
    word_t fetch_data;
    logic  data_req;
    logic  data_we;
    word_t data_addr;
    word_t data_wdata;
    logic  data_ack;
    word_t data_rdata;

    logic [7:0] op_list [max_entries];
    word_t addr_list [max_entries];
    word_t value_list [max_entries];
    int data_before [max_entries]; // data port entries ahead in file order
    int n_entries;
    int data_done;
    logic loaded;

    mem_subsystem_top i_dut (.*);

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            fail_run($sformatf("ERROR %s expected 0x%08h actual 0x%08h", name, expected, actual));
        end
    endtask

    task automatic check_ack(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            fail_run($sformatf("ERROR %s expected 0x%0h actual 0x%0h", name, expected, actual));
        end
    endtask

    function automatic int unsigned lcg_next(input int unsigned state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic load_golden();
        int fd;
        int data_seen;
        string text;
        logic [7:0] op;
        word_t a;
        word_t v;
        fd = $fopen("tests/mem_golden.txt", "r");
        if (fd == 0) begin
            fail_run("could not open the golden file tests/mem_golden.txt");
        end
        n_entries = 0;
        data_seen = 0;
        while ($fgets(text, fd) > 0) begin
            if (text.getc(0) != "#" && $sscanf(text, "%c %h %h", op, a, v) == 3) begin
                if (op != "F" && op != "L" && op != "S") begin
                    fail_run("golden file holds an unknown operation");
                end
                op_list[n_entries] = op;
                addr_list[n_entries] = a;
                value_list[n_entries] = v;
                data_before[n_entries] = data_seen;
                if (op != "F") begin
                    data_seen++;
                end
                n_entries++;
            end
        end
        $fclose(fd);
    endtask

    task automatic run_fetch(input word_t addr, input word_t expected, input int idle);
        repeat (idle) @(posedge clk);
        @(negedge clk);
        check_ack("fetch_ack", 1'b0, fetch_ack);
        @(posedge clk);
        fetch_req <= 1'b1;
        fetch_addr <= addr;
        @(negedge clk);
        while (!fetch_ack) @(negedge clk);
        check_word("fetch_data", expected, fetch_data);
        @(posedge clk);
        fetch_req <= 1'b0;
        @(negedge clk);
        check_ack("fetch_ack", 1'b1, fetch_ack); // ack outlives req by a cycle
        check_word("fetch_data", expected, fetch_data);
        while (fetch_ack) @(negedge clk);
    endtask

    task automatic run_data(input logic we, input word_t addr, input word_t value, input int idle);
        repeat (idle) @(posedge clk);
        @(negedge clk);
        check_ack("data_ack", 1'b0, data_ack);
        @(posedge clk);
        data_req <= 1'b1;
        data_we <= we;
        data_addr <= addr;
        data_wdata <= value;
        @(negedge clk);
        while (!data_ack) @(negedge clk);
        if (!we) begin
            check_word("data_rdata", value, data_rdata);
        end
        @(posedge clk);
        data_req <= 1'b0;
        @(negedge clk);
        check_ack("data_ack", 1'b1, data_ack);
        if (!we) begin
            check_word("data_rdata", value, data_rdata); // held while ack is up
        end
        while (data_ack) @(negedge clk);
    endtask

    task automatic fetch_worker();
        int unsigned seed = 30;
        for (int i = 0; i < n_entries; i++) begin
            if (op_list[i] == "F") begin
                wait (data_done >= data_before[i]); // earlier stores are in the store
                seed = lcg_next(seed);
                run_fetch(addr_list[i], value_list[i], int'((seed >> 16) & 3));
            end
        end
    endtask

    task automatic data_worker();
        int unsigned seed = 30;
        for (int i = 0; i < n_entries; i++) begin
            if (op_list[i] != "F") begin
                seed = lcg_next(seed);
                run_data(op_list[i] == "S", addr_list[i], value_list[i], int'((seed >> 16) & 3));
                data_done++;
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // watchdog sized from the golden entry count
    initial begin
        wait (loaded);
        #(n_entries * cycles_per_entry * clk_period + reset_cycles * clk_period);
        fail_run("timeout: the run hung waiting for a handshake to finish");
    end

    initial begin
        reset = 1'b1;
        fetch_req = 1'b0;
        fetch_addr = '0;
        data_req = 1'b0;
        data_we = 1'b0;
        data_addr = '0;
        data_wdata = '0;
        data_done = 0;
        loaded = 1'b0;
        load_golden();
        loaded = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_ack("fetch_ack", 1'b0, fetch_ack);
        check_ack("data_ack", 1'b0, data_ack);
        fork
            fetch_worker();
            data_worker();
        join
        $display("All tests passed");
        $finish;
    end

endmodule
